//--- design/vec_pkg.sv
package vec_pkg;

  // Lane format shared by the register file and both lane units
  localparam int LANES  = 4;
  localparam int LANE_W = 16;
  localparam int VEC_W  = LANES * LANE_W;

  localparam int REG_N  = 8;
  localparam int REG_AW = $clog2(REG_N);

  // Four 32-bit products summed with wraparound
  localparam int DOT_W  = 32;

  // bf16 layout is sign, 8-bit exponent, 7-bit mantissa
  localparam int BF_EXP_W   = 8;
  localparam int BF_MAN_W   = 7;
  localparam int BF_BIAS    = 127;
  localparam int BF_EXP_MAX = 255;  // All-ones exponent marks infinity

  // Codes not listed here act as NOP
  typedef enum logic [3:0] {
    OP_NOP   = 4'd0,
    OP_LDI   = 4'd1,
    OP_ADD   = 4'd4,
    OP_SUB   = 4'd5,
    OP_DOT   = 4'd6,
    OP_RELU  = 4'd7,
    OP_BMUL  = 4'd11,
    OP_BRELU = 4'd13
  } vec_op_e;

endpackage

//--- design/vec_regfile.sv
`timescale 1ns/1ns

module vec_regfile import vec_pkg::*; (
  input  logic              clk,
  input  logic              wr_en,
  input  logic [REG_AW-1:0] wr_addr,
  input  logic [VEC_W-1:0]  wr_data,
  input  logic [REG_AW-1:0] rd_addr_a,
  input  logic [REG_AW-1:0] rd_addr_b,
  output logic [VEC_W-1:0]  rd_data_a,
  output logic [VEC_W-1:0]  rd_data_b
);

  logic [VEC_W-1:0] regs [REG_N];

  // Reads see the value written at the previous edge, so back-to-back issue needs no bypass
  assign rd_data_a = regs[rd_addr_a];
  assign rd_data_b = regs[rd_addr_b];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      regs[wr_addr] <= wr_data;
    end
  end

endmodule

//--- design/int16_lanes.sv
`timescale 1ns/1ns

module int16_lanes import vec_pkg::*; (
  input  vec_op_e           op,
  input  logic [VEC_W-1:0]  operand_a,
  input  logic [VEC_W-1:0]  operand_b,
  input  logic [LANE_W-1:0] imm,
  output logic [VEC_W-1:0]  int_result
);

  logic signed [LANE_W-1:0] a_lane [LANES];
  logic signed [LANE_W-1:0] b_lane [LANES];
  logic        [VEC_W-1:0]  lane_res;
  logic signed [DOT_W-1:0]  dot_sum;

  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      a_lane[i] = operand_a[i*LANE_W +: LANE_W];
      b_lane[i] = operand_b[i*LANE_W +: LANE_W];
    end
  end

  // Each lane wraps on its own and no carry crosses a lane boundary
  always_comb begin
    lane_res = '0;
    for (int i = 0; i < LANES; i++) begin
      case (op)
        OP_ADD:  lane_res[i*LANE_W +: LANE_W] = a_lane[i] + b_lane[i];
        OP_SUB:  lane_res[i*LANE_W +: LANE_W] = a_lane[i] - b_lane[i];
        OP_RELU: lane_res[i*LANE_W +: LANE_W] = a_lane[i][LANE_W-1] ? '0 : a_lane[i];
        default: lane_res[i*LANE_W +: LANE_W] = '0;
      endcase
    end
  end

  always_comb begin
    dot_sum = '0;
    for (int i = 0; i < LANES; i++) begin
      dot_sum = dot_sum + a_lane[i] * b_lane[i];  // Sum of signed products wraps at DOT_W
    end
  end

  always_comb begin
    case (op)
      OP_LDI:                  int_result = {LANES{imm}};
      OP_ADD, OP_SUB, OP_RELU: int_result = lane_res;
      OP_DOT:                  int_result = {{(VEC_W-DOT_W){1'b0}}, dot_sum};
      default:                 int_result = '0;
    endcase
  end

endmodule

//--- design/bf16_lanes.sv
`timescale 1ns/1ns

module bf16_lanes import vec_pkg::*; (
  input  vec_op_e          op,
  input  logic [VEC_W-1:0] operand_a,
  input  logic [VEC_W-1:0] operand_b,
  output logic [VEC_W-1:0] bf_result
);

  // Truncating multiply with no subnormal or NaN handling
  function automatic logic [LANE_W-1:0] bf16_mul(input logic [LANE_W-1:0] x,
                                                 input logic [LANE_W-1:0] y);
    logic                  sign;
    logic [BF_EXP_W-1:0]   exp_x;
    logic [BF_EXP_W-1:0]   exp_y;
    logic [BF_EXP_W-1:0]   exp_r;
    logic [BF_MAN_W:0]     sig_x;
    logic [BF_MAN_W:0]     sig_y;
    logic [2*BF_MAN_W+1:0] prod;
    logic [BF_MAN_W-1:0]   man;
    sign  = x[LANE_W-1] ^ y[LANE_W-1];
    exp_x = x[LANE_W-2 -: BF_EXP_W];
    exp_y = y[LANE_W-2 -: BF_EXP_W];
    sig_x = {1'b1, x[BF_MAN_W-1:0]};
    sig_y = {1'b1, y[BF_MAN_W-1:0]};
    prod  = sig_x * sig_y;
    exp_r = exp_x + exp_y - BF_EXP_W'(BF_BIAS);  // Wraps modulo 256
    if (prod[2*BF_MAN_W+1]) begin
      exp_r = exp_r + 1'b1;
      man   = prod[2*BF_MAN_W -: BF_MAN_W];
    end else begin
      man   = prod[2*BF_MAN_W-1 -: BF_MAN_W];
    end
    if (x[LANE_W-2:0] == '0 || y[LANE_W-2:0] == '0) begin
      bf16_mul = '0;  // A zero operand wins even against infinity
    end else if (exp_x == BF_EXP_W'(BF_EXP_MAX) || exp_y == BF_EXP_W'(BF_EXP_MAX)) begin
      bf16_mul = {sign, BF_EXP_W'(BF_EXP_MAX), {BF_MAN_W{1'b0}}};
    end else begin
      bf16_mul = {sign, exp_r, man};
    end
  endfunction

  logic [LANE_W-1:0] a_lane [LANES];
  logic [LANE_W-1:0] b_lane [LANES];

  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      a_lane[i] = operand_a[i*LANE_W +: LANE_W];
      b_lane[i] = operand_b[i*LANE_W +: LANE_W];
    end
  end

  always_comb begin
    bf_result = '0;
    for (int i = 0; i < LANES; i++) begin
      case (op)
        OP_BMUL:  bf_result[i*LANE_W +: LANE_W] = bf16_mul(a_lane[i], b_lane[i]);
        OP_BRELU: bf_result[i*LANE_W +: LANE_W] = a_lane[i][LANE_W-1] ? '0 : a_lane[i];
        default:  bf_result[i*LANE_W +: LANE_W] = '0;
      endcase
    end
  end

endmodule

//--- design/vec_writeback.sv
`timescale 1ns/1ns

module vec_writeback import vec_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              instr_valid,
  input  vec_op_e           op,
  input  logic [REG_AW-1:0] rd,
  input  logic [VEC_W-1:0]  int_result,
  input  logic [VEC_W-1:0]  bf_result,
  output logic              wr_en,
  output logic [REG_AW-1:0] wr_addr,
  output logic [VEC_W-1:0]  wr_data,
  output logic              result_valid,
  output logic [REG_AW-1:0] result_rd,
  output logic [VEC_W-1:0]  result_data
);

  logic op_writes;
  logic use_bf;

  // Only the routing is decided here and the lane units own the arithmetic
  always_comb begin
    op_writes = 1'b0;
    use_bf    = 1'b0;
    case (op)
      OP_LDI, OP_ADD, OP_SUB, OP_DOT, OP_RELU: begin
        op_writes = 1'b1;
      end
      OP_BMUL, OP_BRELU: begin
        op_writes = 1'b1;
        use_bf    = 1'b1;
      end
      default: ;
    endcase
  end

  assign wr_en   = instr_valid & op_writes;  // Register file updates at the issue edge
  assign wr_addr = rd;
  assign wr_data = use_bf ? bf_result : int_result;

  always_ff @(posedge clk) begin
    if (rst) begin
      result_valid <= 1'b0;
    end else begin
      result_valid <= wr_en;
    end
  end

  always_ff @(posedge clk) begin
    result_rd   <= rd;
    result_data <= wr_data;
  end

endmodule

//--- design/vec_unit.sv
`timescale 1ns/1ns

module vec_unit import vec_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              instr_valid,
  input  vec_op_e           op,
  input  logic [REG_AW-1:0] rd,
  input  logic [REG_AW-1:0] rs1,
  input  logic [REG_AW-1:0] rs2,
  input  logic [LANE_W-1:0] imm,
  output logic              result_valid,
  output logic [REG_AW-1:0] result_rd,
  output logic [VEC_W-1:0]  result_data
);

  logic [VEC_W-1:0]  operand_a;
  logic [VEC_W-1:0]  operand_b;
  logic [VEC_W-1:0]  int_result;
  logic [VEC_W-1:0]  bf_result;
  logic              wr_en;
  logic [REG_AW-1:0] wr_addr;
  logic [VEC_W-1:0]  wr_data;

  vec_regfile i_regfile (
    .clk       (clk),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .rd_addr_a (rs1),
    .rd_addr_b (rs2),
    .rd_data_a (operand_a),
    .rd_data_b (operand_b)
  );

  // Both lane units see every instruction and idle to zero on foreign ops
  int16_lanes i_int16_lanes (
    .op         (op),
    .operand_a  (operand_a),
    .operand_b  (operand_b),
    .imm        (imm),
    .int_result (int_result)
  );

  bf16_lanes i_bf16_lanes (
    .op        (op),
    .operand_a (operand_a),
    .operand_b (operand_b),
    .bf_result (bf_result)
  );

  vec_writeback i_writeback (
    .clk          (clk),
    .rst          (rst),
    .instr_valid  (instr_valid),
    .op           (op),
    .rd           (rd),
    .int_result   (int_result),
    .bf_result    (bf_result),
    .wr_en        (wr_en),
    .wr_addr      (wr_addr),
    .wr_data      (wr_data),
    .result_valid (result_valid),
    .result_rd    (result_rd),
    .result_data  (result_data)
  );

endmodule

//--- testbench/vec_checker.sv
`timescale 1ns/1ns

module vec_checker import vec_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              result_valid,
  input  logic [REG_AW-1:0] result_rd,
  input  logic [VEC_W-1:0]  result_data,
  input  logic              exp_valid,
  input  logic [REG_AW-1:0] exp_rd,
  input  logic [VEC_W-1:0]  exp_data,
  input  logic [127:0]      exp_name,
  output int                value_errors,
  output int                valid_errors
);

  // Expected values always describe the instruction issued one cycle back
  always @(posedge clk) begin
    if (rst) begin
      value_errors = 0;
      valid_errors = 0;
    end else if (result_valid !== exp_valid) begin
      valid_errors++;
      if (exp_valid) begin
        $display("no result_valid for test %0s, a write result was due", exp_name);
      end else begin
        $display("result_valid came up after test %0s, which writes nothing", exp_name);
      end
    end else if (exp_valid) begin
      if (result_rd !== exp_rd) begin
        value_errors++;
        $display("error %0s result_rd expected %0d actual %0d", exp_name, exp_rd, result_rd);
      end
      if (result_data !== exp_data) begin
        value_errors++;
        $display("error %0s result_data expected %h actual %h",
                 exp_name, exp_data, result_data);
      end
    end
  end

endmodule

//--- testbench/vec_assertions.sv
`timescale 1ns/1ns

module vec_assertions import vec_pkg::*; (
  input logic              clk,
  input logic              rst,
  input logic              instr_valid,
  input vec_op_e           op,
  input logic [REG_AW-1:0] rd,
  input logic              result_valid,
  input logic [REG_AW-1:0] result_rd
);

  logic issue_write;

  always_comb begin
    case (op)
      OP_LDI, OP_ADD, OP_SUB, OP_DOT, OP_RELU, OP_BMUL, OP_BRELU: issue_write = instr_valid;
      default: issue_write = 1'b0;
    endcase
  end

  valid_low_after_reset: assert property (@(posedge clk) rst |=> !result_valid)
    else $error("result_valid high in the cycle after reset");

  // Exactly one cycle of latency in both directions
  result_follows_write: assert property (
    @(posedge clk) disable iff (rst) issue_write |=> result_valid)
    else $error("writing instruction gave no result_valid one cycle later");

  no_result_without_write: assert property (
    @(posedge clk) disable iff (rst) !issue_write |=> !result_valid)
    else $error("result_valid without a writing instruction one cycle earlier");

  result_rd_matches: assert property (
    @(posedge clk) disable iff (rst) result_valid |-> result_rd == $past(rd))
    else $error("result_rd differs from the rd issued one cycle earlier");

endmodule

bind vec_unit vec_assertions i_vec_assertions (
  .clk          (clk),
  .rst          (rst),
  .instr_valid  (instr_valid),
  .op           (op),
  .rd           (rd),
  .result_valid (result_valid),
  .result_rd    (result_rd)
);

//--- testbench/vec_unit_tb.sv
`timescale 1ns/1ns

module vec_unit_tb import vec_pkg::*; ();

  localparam int RESET_CYCLES = 3;

  logic              clk;
  logic              rst;
  logic              instr_valid;
  vec_op_e           op;
  logic [REG_AW-1:0] rd;
  logic [REG_AW-1:0] rs1;
  logic [REG_AW-1:0] rs2;
  logic [LANE_W-1:0] imm;
  logic              result_valid;
  logic [REG_AW-1:0] result_rd;
  logic [VEC_W-1:0]  result_data;

  logic              exp_valid;
  logic [REG_AW-1:0] exp_rd;
  logic [VEC_W-1:0]  exp_data;
  logic [127:0]      exp_name;
  int                value_errors;
  int                valid_errors;
  int                cycle_limit;
  int                cycles = 0;

  // Stimulus table with one row per issued instruction
  logic [127:0]      name_q [$];
  logic [3:0]        op_q [$];
  logic [REG_AW-1:0] rd_q [$];
  logic [REG_AW-1:0] rs1_q [$];
  logic [REG_AW-1:0] rs2_q [$];
  logic [LANE_W-1:0] imm_q [$];
  logic              writes_q [$];
  logic [VEC_W-1:0]  data_q [$];

  vec_unit i_vec_unit (
    .clk          (clk),
    .rst          (rst),
    .instr_valid  (instr_valid),
    .op           (op),
    .rd           (rd),
    .rs1          (rs1),
    .rs2          (rs2),
    .imm          (imm),
    .result_valid (result_valid),
    .result_rd    (result_rd),
    .result_data  (result_data)
  );

  vec_checker i_checker (
    .clk          (clk),
    .rst          (rst),
    .result_valid (result_valid),
    .result_rd    (result_rd),
    .result_data  (result_data),
    .exp_valid    (exp_valid),
    .exp_rd       (exp_rd),
    .exp_data     (exp_data),
    .exp_name     (exp_name),
    .value_errors (value_errors),
    .valid_errors (valid_errors)
  );

  always #2 clk = ~clk;

  task automatic add_test(input logic [127:0] name, input logic [3:0] code, input int dst,
                          input int src1, input int src2, input logic [LANE_W-1:0] value,
                          input logic writes, input logic [VEC_W-1:0] data);
    name_q.push_back(name);
    op_q.push_back(code);
    rd_q.push_back(dst[REG_AW-1:0]);
    rs1_q.push_back(src1[REG_AW-1:0]);
    rs2_q.push_back(src2[REG_AW-1:0]);
    imm_q.push_back(value);
    writes_q.push_back(writes);
    data_q.push_back(data);
  endtask

  task automatic build_table();
    add_test("ldi_r0", OP_LDI, 0, 0, 0, 16'h7fff, 1'b1, 64'h7fff_7fff_7fff_7fff);
    add_test("ldi_r1", OP_LDI, 1, 0, 0, 16'h0001, 1'b1, 64'h0001_0001_0001_0001);
    add_test("ldi_r2", OP_LDI, 2, 0, 0, 16'hffff, 1'b1, 64'hffff_ffff_ffff_ffff);
    add_test("ldi_r3", OP_LDI, 3, 0, 0, 16'h8000, 1'b1, 64'h8000_8000_8000_8000);
    add_test("ldi_r4", OP_LDI, 4, 0, 0, 16'h5a5a, 1'b1, 64'h5a5a_5a5a_5a5a_5a5a);
    add_test("ldi_r5", OP_LDI, 5, 0, 0, 16'ha5a5, 1'b1, 64'ha5a5_a5a5_a5a5_a5a5);
    add_test("ldi_r6", OP_LDI, 6, 0, 0, 16'h0080, 1'b1, 64'h0080_0080_0080_0080);
    add_test("ldi_r7", OP_LDI, 7, 0, 0, 16'hff00, 1'b1, 64'hff00_ff00_ff00_ff00);
    // sub_b2b reads r4 one cycle after add_ovf wrote it
    add_test("add_ovf", OP_ADD, 4, 0, 1, 16'h0, 1'b1, 64'h8000_8000_8000_8000);
    add_test("sub_b2b", OP_SUB, 5, 4, 1, 16'h0, 1'b1, 64'h7fff_7fff_7fff_7fff);
    add_test("add_carry", OP_ADD, 6, 2, 2, 16'h0, 1'b1, 64'hfffe_fffe_fffe_fffe);
    add_test("add_neg", OP_ADD, 7, 3, 2, 16'h0, 1'b1, 64'h7fff_7fff_7fff_7fff);
    add_test("sub_neg", OP_SUB, 6, 1, 0, 16'h0, 1'b1, 64'h8002_8002_8002_8002);
    // 4 x (-1 x 32767) leaves a negative lane 1 next to a positive lane 0
    add_test("dot_mixed", OP_DOT, 4, 2, 0, 16'h0, 1'b1, 64'h0000_0000_fffe_0004);
    add_test("relu_mixed", OP_RELU, 5, 4, 0, 16'h0, 1'b1, 64'h0000_0000_0000_0004);
    add_test("dot_ovf", OP_DOT, 5, 0, 0, 16'h0, 1'b1, 64'h0000_0000_fffc_0004);
    add_test("dot_wrap", OP_DOT, 6, 3, 3, 16'h0, 1'b1, 64'h0000_0000_0000_0000);
    add_test("ldi_bf_1p5", OP_LDI, 0, 0, 0, 16'h3fc0, 1'b1, 64'h3fc0_3fc0_3fc0_3fc0);
    add_test("ldi_bf_1p0", OP_LDI, 1, 0, 0, 16'h3f80, 1'b1, 64'h3f80_3f80_3f80_3f80);
    add_test("ldi_bf_m2", OP_LDI, 2, 0, 0, 16'hc000, 1'b1, 64'hc000_c000_c000_c000);
    add_test("ldi_bf_inf", OP_LDI, 3, 0, 0, 16'h7f80, 1'b1, 64'h7f80_7f80_7f80_7f80);
    add_test("bmul_ovf", OP_BMUL, 5, 0, 0, 16'h0, 1'b1, 64'h4010_4010_4010_4010);
    add_test("bmul_neg", OP_BMUL, 7, 1, 2, 16'h0, 1'b1, 64'hc000_c000_c000_c000);
    // -2.0 times zero still gives +0
    add_test("bmul_zero", OP_BMUL, 5, 2, 6, 16'h0, 1'b1, 64'h0000_0000_0000_0000);
    add_test("bmul_inf", OP_BMUL, 5, 3, 2, 16'h0, 1'b1, 64'hff80_ff80_ff80_ff80);
    add_test("brelu_mixed", OP_BRELU, 7, 4, 0, 16'h0, 1'b1, 64'h0000_0000_0000_0004);
    add_test("brelu_pos", OP_BRELU, 6, 0, 0, 16'h0, 1'b1, 64'h3fc0_3fc0_3fc0_3fc0);
    // r1 must still hold 1.0 in bf16 after both no-write ops
    add_test("nop", OP_NOP, 1, 0, 0, 16'h0, 1'b0, 64'h0);
    add_test("undef_op", 4'd9, 1, 0, 0, 16'h0, 1'b0, 64'h0);
    add_test("add_after_nop", OP_ADD, 2, 1, 1, 16'h0, 1'b1, 64'h7f00_7f00_7f00_7f00);
  endtask

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("timeout after %0d cycles, the test loop did not finish", cycle_limit);
      $display("tests failed");
      $finish;
    end
  end

  initial begin
    clk         = 1'b0;
    rst         = 1'b1;
    instr_valid = 1'b0;
    op          = OP_NOP;
    rd          = '0;
    rs1         = '0;
    rs2         = '0;
    imm         = '0;
    exp_valid   = 1'b0;
    exp_rd      = '0;
    exp_data    = '0;
    exp_name    = "reset";
    build_table();
    cycle_limit = op_q.size() + RESET_CYCLES + 20;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (int i = 0; i <= op_q.size(); i++) begin
      if (i > 0) begin
        exp_valid = writes_q[i-1];  // Row i-1 shows its result during this cycle
        exp_rd    = rd_q[i-1];
        exp_data  = data_q[i-1];
        exp_name  = name_q[i-1];
      end
      if (i < op_q.size()) begin
        instr_valid = 1'b1;
        op          = vec_op_e'(op_q[i]);
        rd          = rd_q[i];
        rs1         = rs1_q[i];
        rs2         = rs2_q[i];
        imm         = imm_q[i];
      end else begin
        instr_valid = 1'b0;
        op          = OP_NOP;
      end
      @(negedge clk);
    end
    exp_valid = 1'b0;
    exp_name  = "idle";
    @(negedge clk);
    $display("run complete: %0d value errors, %0d valid errors", value_errors, valid_errors);
    if (value_errors + valid_errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- filelist.f
design/vec_pkg.sv
design/vec_regfile.sv
design/int16_lanes.sv
design/bf16_lanes.sv
design/vec_writeback.sv
design/vec_unit.sv
testbench/vec_checker.sv
testbench/vec_assertions.sv
testbench/vec_unit_tb.sv

//--- Makefile
.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --assert --top-module vec_unit_tb -f filelist.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module vec_unit_tb \
	  -f filelist.f -o vec_unit_sim
	./obj_dir/vec_unit_sim > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "tests failed" sim.log || ! grep -q "all tests passed" sim.log; then \
	  echo "simulation reported failure"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
